// File: bench/multicomp_io_tb.sv
// ========================================
// Testbench for the multicomp board I/O glue
// Vector-driven, random serial line levels
// ========================================
`timescale 1ns/1ns

module multicomp_io_tb;
	import multicomp_pkg::*;

	// Words per vector line
	localparam int STEP_WORDS = 7;
	localparam int MAX_STEPS  = 64;
	localparam logic [63:0] END_MARK = 64'hffff_ffff_ffff_ffff;

	logic                  clk_sys;
	logic                  RESET;
	logic [OPT_W-1:0]      opt;
	logic                  user_button;
	logic                  img_mounted;
	logic [IMG_SIZE_W-1:0] img_size;
	logic                  sys_reset;
	baud_inc_t             baud_inc;
	logic                  host_txd;
	logic                  host_rts;
	logic                  host_rxd;
	logic                  host_cts;
	logic                  uart_rxd;
	logic                  uart_cts;
	logic                  uart_txd;
	logic                  uart_rts;
	logic [6:0]            user_in;
	logic [6:0]            user_out;
	logic                  core_sd_cs;
	logic                  core_sd_sck;
	logic                  core_sd_mosi;
	logic                  core_sd_miso;
	logic                  card_miso;
	logic                  vsd_miso;
	logic                  sd_cs;
	logic                  sd_sck;
	logic                  sd_mosi;
	logic                  vsd_ss;
	logic                  led_user;

	logic [63:0] stim_mem [0:STEP_WORDS*MAX_STEPS-1];
	integer      seed;
	int          errors = 0;
	int          failures = 0;
	int          checks = 0;
	int          cycles = 0;
	int          cycle_limit = 1000;
	int          n_steps = 0;

	multicomp_io multicomp_io_inst (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.opt          (opt),
		.user_button  (user_button),
		.img_mounted  (img_mounted),
		.img_size     (img_size),
		.sys_reset    (sys_reset),
		.baud_inc     (baud_inc),
		.host_txd     (host_txd),
		.host_rts     (host_rts),
		.host_rxd     (host_rxd),
		.host_cts     (host_cts),
		.uart_rxd     (uart_rxd),
		.uart_cts     (uart_cts),
		.uart_txd     (uart_txd),
		.uart_rts     (uart_rts),
		.user_in      (user_in),
		.user_out     (user_out),
		.core_sd_cs   (core_sd_cs),
		.core_sd_sck  (core_sd_sck),
		.core_sd_mosi (core_sd_mosi),
		.core_sd_miso (core_sd_miso),
		.card_miso    (card_miso),
		.vsd_miso     (vsd_miso),
		.sd_cs        (sd_cs),
		.sd_sck       (sd_sck),
		.sd_mosi      (sd_mosi),
		.vsd_ss       (vsd_ss),
		.led_user     (led_user)
	);

	// 100 ns clock
	initial clk_sys = 1'b0;
	always #50 clk_sys = ~clk_sys;

	// Watchdog on total edges
	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit) begin
			$display("Timeout: run went past %0d cycles without finishing", cycle_limit);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// ========================================
	// Compare tasks
	// ========================================
	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t ns: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_baud(input string name, input baud_inc_t got, input baud_inc_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_user(input string name, input logic [6:0] got, input logic [6:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t ns: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// ========================================
	// Vector handling
	// ========================================
	// Vector inputs plus random serial levels
	task automatic drive_step(input int base);
		logic [31:0] r;
		r            = $unsigned($random(seed));
		opt          = stim_mem[base+1][OPT_W-1:0];
		user_button  = stim_mem[base+2][0];
		img_mounted  = stim_mem[base+2][1];
		img_size     = stim_mem[base+3];
		core_sd_cs   = stim_mem[base+4][0];
		core_sd_sck  = stim_mem[base+4][1];
		core_sd_mosi = stim_mem[base+4][2];
		card_miso    = stim_mem[base+4][3];
		vsd_miso     = stim_mem[base+4][4];
		uart_rxd     = r[0];
		uart_cts     = r[1];
		host_txd     = r[2];
		host_rts     = r[3];
		user_in      = r[10:4];
	endtask

	// Ends 10 ns before the next edge
	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clk_sys);
			#5;
			// Mount is a one-cycle pulse
			img_mounted = 1'b0;
		end
		#85;
	endtask

	task automatic verify_step(input int base);
		logic [15:0] flags;
		logic        port_user;
		logic        flow;
		logic        vsd;
		logic        cts_src;
		logic [6:0]  user_exp;
		flags     = stim_mem[base+6][15:0];
		port_user = opt[OPT_PORT_SEL];
		flow      = opt[OPT_FLOW_EN];
		vsd       = flags[2];
		check_baud("baud_inc", baud_inc, stim_mem[base+5][BAUD_INC_W-1:0]);
		check_bit("sys_reset", sys_reset, flags[0]);
		// Serial routing by port and flow control
		cts_src = port_user ? user_in[3] : uart_cts;
		check_bit("host_rxd", host_rxd, port_user ? user_in[0] : uart_rxd);
		check_bit("host_cts", host_cts, flow & flags[1] & cts_src);
		check_bit("uart_txd", uart_txd, port_user ? 1'b1 : host_txd);
		check_bit("uart_rts", uart_rts, (flow & ~port_user) ? host_rts : 1'b1);
		if (port_user) begin
			user_exp = {3'b000, flow, flow ? host_rts : 1'b1, host_txd, 1'b1};
		end else begin
			user_exp = 7'b0000110;
		end
		check_user("user_out", user_out, user_exp);
		// SD path, physical pins parked when virtual
		check_bit("sd_cs", sd_cs, vsd ? 1'b1 : core_sd_cs);
		check_bit("sd_sck", sd_sck, vsd ? 1'b0 : core_sd_sck);
		check_bit("sd_mosi", sd_mosi, vsd ? 1'b0 : core_sd_mosi);
		check_bit("vsd_ss", vsd_ss, vsd ? core_sd_cs : 1'b1);
		check_bit("core_sd_miso", core_sd_miso, vsd ? vsd_miso : card_miso);
		check_bit("led_user", led_user, flags[3]);
	endtask

	// ========================================
	// Main sequence
	// ========================================
	initial begin
		int step;
		seed         = 32'hdcc1;
		RESET        = 1'b1;
		opt          = '0;
		user_button  = 1'b0;
		img_mounted  = 1'b0;
		img_size     = '0;
		host_txd     = 1'b1;
		host_rts     = 1'b1;
		uart_rxd     = 1'b1;
		uart_cts     = 1'b0;
		user_in      = '0;
		core_sd_cs   = 1'b1;
		core_sd_sck  = 1'b0;
		core_sd_mosi = 1'b0;
		card_miso    = 1'b0;
		vsd_miso     = 1'b0;
		$readmemh("bench/multicomp_stim.txt", stim_mem);
		// Count steps up to the end marker, limit from total wait
		while (n_steps < MAX_STEPS && stim_mem[n_steps*STEP_WORDS] != END_MARK) begin
			cycle_limit = cycle_limit + int'(stim_mem[n_steps*STEP_WORDS][31:0]);
			n_steps++;
		end
		if (n_steps == 0) begin
			failures++;
			$display("No stimulus steps were read from the vector file");
		end
		repeat (5) @(posedge clk_sys);
		#5;
		RESET = 1'b0;
		for (step = 0; step < n_steps; step++) begin
			@(posedge clk_sys);
			#5;
			drive_step(step * STEP_WORDS);
			wait_cycles(int'(stim_mem[step*STEP_WORDS][31:0]));
			verify_step(step * STEP_WORDS);
		end
		$display("Done: %0d steps, %0d checks, %0d mismatches, %0d other failures",
			n_steps, checks, errors, failures);
		if (errors == 0 && failures == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: bench/multicomp_stim.txt
// wait opt ctl(b0 button, b1 mount) img_size sd(b0 cs, b1 sck, b2 mosi, b3 card_miso, b4 vsd_miso)
// exp_baud exp_flags(b0 sys_reset, b1 cts passed, b2 vsd_sel, b3 led_user); ffff... ends the list
// Baud table, codes 0 to 7
2 0000 0 0 01 0970 0
2 0200 0 0 01 0325 0
2 0400 0 0 01 0193 0
2 0600 0 0 01 00c9 0
2 0800 0 0 01 0065 0
2 0a00 0 0 01 0032 0
2 0c00 0 0 01 0970 0
2 0e00 0 0 01 0970 0
// Port routing and flow control before and after settling
2 1000 0 0 01 0970 0
2 4000 0 0 01 0970 0
2 5000 0 0 01 0970 0
c350 4000 0 0 01 0970 2
2 5000 0 0 01 0970 2
2 0000 0 0 01 0970 2
// Menu reset, user button, mount reset stretch
1 0001 0 0 01 0970 1
1 0000 1 0 01 0970 1
1 0000 0 0 01 0970 0
2 8000 0 0 01 0970 0
3 8000 2 0 01 0970 1
fff0 8000 0 0 01 0970 1
e 8000 0 0 01 0970 0
// SD select and activity light
2 0000 0 0 06 0970 0
10004 0000 0 0 06 0970 0
2 0000 2 100000 06 0970 4
2 0000 0 100000 02 0970 c
2 0000 0 100000 12 0970 c
10004 0000 0 100000 12 0970 4
2 0000 2 0 12 0970 0
2 0000 0 0 0e 0970 0
ffffffffffffffff

// File: multicomp_io.f
src/multicomp_pkg.sv
src/option_decoder.sv
src/reset_sequencer.sv
src/serial_router.sv
src/sd_activity_monitor.sv
src/multicomp_io.sv
bench/multicomp_io_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the multicomp_io testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --top-module multicomp_io_tb -f multicomp_io.f \
	-o multicomp_io_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	echo "Verilator build failed, see $BUILD_LOG"
	exit 1
fi

./obj_dir/multicomp_io_sim > "$SIM_LOG" 2>&1
if [ $? -ne 0 ]; then
	echo "Simulation exited with an error, see $SIM_LOG"
	exit 1
fi

if grep -q "TESTBENCH PASSED" "$SIM_LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see $SIM_LOG"
	exit 1
fi

// File: src/multicomp_io.sv
// ========================================
// Multicomp board I/O top level
// Config, reset, serial and SD pin glue
// ========================================
`timescale 1ns/1ns

module multicomp_io (
	input  logic                                clk_sys,
	input  logic                                RESET,
	input  logic [multicomp_pkg::OPT_W-1:0]      opt,
	input  logic                                user_button,
	input  logic                                img_mounted,
	input  logic [multicomp_pkg::IMG_SIZE_W-1:0] img_size,
	output logic                                sys_reset,
	output multicomp_pkg::baud_inc_t            baud_inc,
	// Serial, core side
	input  logic                                host_txd,
	input  logic                                host_rts,
	output logic                                host_rxd,
	output logic                                host_cts,
	// Serial pins
	input  logic                                uart_rxd,
	input  logic                                uart_cts,
	output logic                                uart_txd,
	output logic                                uart_rts,
	input  logic [6:0]                          user_in,
	output logic [6:0]                          user_out,
	// SD, core side
	input  logic                                core_sd_cs,
	input  logic                                core_sd_sck,
	input  logic                                core_sd_mosi,
	output logic                                core_sd_miso,
	// SD pins and virtual card
	input  logic                                card_miso,
	input  logic                                vsd_miso,
	output logic                                sd_cs,
	output logic                                sd_sck,
	output logic                                sd_mosi,
	output logic                                vsd_ss,
	output logic                                led_user
);
	import multicomp_pkg::*;

	cfg_t cfg;

	// Increment goes straight to the core's UART
	assign baud_inc = cfg.baud_inc;

	option_decoder option_decoder_inst (
		.clk_sys (clk_sys),
		.RESET   (RESET),
		.opt     (opt),
		.cfg     (cfg)
	);

	reset_sequencer reset_sequencer_inst (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.opt_reset   (opt[OPT_RESET]),
		.user_button (user_button),
		.img_mounted (img_mounted),
		.cfg         (cfg),
		.sys_reset   (sys_reset)
	);

	serial_router serial_router_inst (
		.clk_sys   (clk_sys),
		.sys_reset (sys_reset),
		.cfg       (cfg),
		.host_txd  (host_txd),
		.host_rts  (host_rts),
		.host_rxd  (host_rxd),
		.host_cts  (host_cts),
		.uart_rxd  (uart_rxd),
		.uart_cts  (uart_cts),
		.uart_txd  (uart_txd),
		.uart_rts  (uart_rts),
		.user_in   (user_in),
		.user_out  (user_out)
	);

	// Select latch on hard reset, timer on system reset
	sd_activity_monitor sd_activity_monitor_inst (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.sys_reset    (sys_reset),
		.img_mounted  (img_mounted),
		.img_size     (img_size),
		.core_sd_cs   (core_sd_cs),
		.core_sd_sck  (core_sd_sck),
		.core_sd_mosi (core_sd_mosi),
		.core_sd_miso (core_sd_miso),
		.card_miso    (card_miso),
		.vsd_miso     (vsd_miso),
		.sd_cs        (sd_cs),
		.sd_sck       (sd_sck),
		.sd_mosi      (sd_mosi),
		.vsd_ss       (vsd_ss),
		.led_user     (led_user)
	);

endmodule

// File: src/multicomp_pkg.sv
// ========================================
// Multicomp board glue shared definitions
// Option bits, baud table, config struct
// ========================================
package multicomp_pkg;

	// Option word layout
	localparam int OPT_W         = 16;
	localparam int OPT_RESET     = 0;
	localparam int OPT_BAUD_LO   = 9;
	localparam int OPT_PORT_SEL  = 12;
	localparam int OPT_FLOW_EN   = 14;
	localparam int OPT_MOUNT_RST = 15;

	// ========================================
	// Baud rate selection
	// ========================================
	typedef enum logic [2:0] {
		BAUD_115200 = 3'd0,
		BAUD_38400  = 3'd1,
		BAUD_19200  = 3'd2,
		BAUD_9600   = 3'd3,
		BAUD_4800   = 3'd4,
		BAUD_2400   = 3'd5
	} baud_sel_t;

	localparam int BAUD_INC_W = 16;
	typedef logic [BAUD_INC_W-1:0] baud_inc_t;

	// Increments for the core's fractional divider
	localparam baud_inc_t INC_115200 = 16'd2416;
	localparam baud_inc_t INC_38400  = 16'd805;
	localparam baud_inc_t INC_19200  = 16'd403;
	localparam baud_inc_t INC_9600   = 16'd201;
	localparam baud_inc_t INC_4800   = 16'd101;
	localparam baud_inc_t INC_2400   = 16'd50;

	// Serial port choice
	typedef enum logic {
		PORT_CONSOLE = 1'b0,
		PORT_USER    = 1'b1
	} port_sel_t;

	// Registered configuration, 19 bits
	typedef struct packed {
		port_sel_t port;
		logic      flow_en;
		logic      mount_rst;
		baud_inc_t baud_inc;
	} cfg_t;

	// Timers
	localparam int MOUNT_RESET_CYCLES = 65536;
	localparam int CTS_SETTLE_CYCLES  = 50000;
	localparam int ACT_HOLD_CYCLES    = 65536;
	localparam int MOUNT_CNT_W  = $clog2(MOUNT_RESET_CYCLES);
	localparam int SETTLE_CNT_W = $clog2(CTS_SETTLE_CYCLES);
	// One extra bit so the expired value fits
	localparam int ACT_CNT_W    = $clog2(ACT_HOLD_CYCLES) + 1;

	localparam int IMG_SIZE_W = 64;

endpackage

// File: src/option_decoder.sv
// ========================================
// Option decoder
// Registers option word fields and baud increment
// ========================================
`timescale 1ns/1ns

module option_decoder (
	input  logic                           clk_sys,
	input  logic                           RESET,
	input  logic [multicomp_pkg::OPT_W-1:0] opt,
	output multicomp_pkg::cfg_t            cfg
);
	import multicomp_pkg::*;

	baud_sel_t baud_sel;
	baud_inc_t baud_inc_next;

	// Pull the 3-bit baud field out of the option word
	assign baud_sel = baud_sel_t'(opt[OPT_BAUD_LO +: $bits(baud_sel_t)]);

	// Baud table lookup
	always_comb begin
		case (baud_sel)
			BAUD_115200: baud_inc_next = INC_115200;
			BAUD_38400:  baud_inc_next = INC_38400;
			BAUD_19200:  baud_inc_next = INC_19200;
			BAUD_9600:   baud_inc_next = INC_9600;
			BAUD_4800:   baud_inc_next = INC_4800;
			BAUD_2400:   baud_inc_next = INC_2400;
			// Unused codes fall back to the fastest rate
			default:     baud_inc_next = INC_115200;
		endcase
	end

	// Config register, only the hard reset clears it
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cfg.port      <= PORT_CONSOLE;
			cfg.flow_en   <= 1'b0;
			cfg.mount_rst <= 1'b0;
			cfg.baud_inc  <= INC_115200;
		end else begin
			cfg.port      <= port_sel_t'(opt[OPT_PORT_SEL]);
			cfg.flow_en   <= opt[OPT_FLOW_EN];
			cfg.mount_rst <= opt[OPT_MOUNT_RST];
			cfg.baud_inc  <= baud_inc_next;
		end
	end

endmodule

// File: src/reset_sequencer.sv
// ========================================
// Reset sequencer
// Combines reset sources, stretches mount reset
// ========================================
`timescale 1ns/1ns

module reset_sequencer (
	input  logic                clk_sys,
	input  logic                RESET,
	input  logic                opt_reset,
	input  logic                user_button,
	input  logic                img_mounted,
	input  multicomp_pkg::cfg_t cfg,
	output logic                sys_reset
);
	import multicomp_pkg::*;

	logic                   stretch;
	logic [MOUNT_CNT_W-1:0] stretch_cnt;
	logic                   mount_trig;

	// Mount only resets the core when the option asks for it
	assign mount_trig = img_mounted & cfg.mount_rst;

	// ========================================
	// Mount reset stretcher
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			stretch     <= 1'b0;
			stretch_cnt <= '0;
		end else if (mount_trig) begin
			// New mount restarts the count
			stretch     <= 1'b1;
			stretch_cnt <= '0;
		end else if (stretch) begin
			if (stretch_cnt == MOUNT_CNT_W'(MOUNT_RESET_CYCLES - 1)) begin
				stretch <= 1'b0;
			end else begin
				stretch_cnt <= stretch_cnt + 1'b1;
			end
		end
	end

	// Hard reset, menu reset, button and stretch
	assign sys_reset = RESET | opt_reset | user_button | stretch;

endmodule

// File: src/sd_activity_monitor.sv
// ========================================
// SD path select and activity light
// Virtual or physical card, pin gating, LED hold
// ========================================
`timescale 1ns/1ns

module sd_activity_monitor (
	input  logic                                clk_sys,
	input  logic                                RESET,
	input  logic                                sys_reset,
	input  logic                                img_mounted,
	input  logic [multicomp_pkg::IMG_SIZE_W-1:0] img_size,
	// Core SPI side
	input  logic                                core_sd_cs,
	input  logic                                core_sd_sck,
	input  logic                                core_sd_mosi,
	output logic                                core_sd_miso,
	// Card MISO sources
	input  logic                                card_miso,
	input  logic                                vsd_miso,
	// Physical pins and virtual card select
	output logic                                sd_cs,
	output logic                                sd_sck,
	output logic                                sd_mosi,
	output logic                                vsd_ss,
	output logic                                led_user
);
	import multicomp_pkg::*;

	logic                 vsd_sel;
	logic                 mosi_q;
	logic                 miso_q;
	logic                 toggle;
	logic                 active;
	logic [ACT_CNT_W-1:0] hold_cnt;

	// ========================================
	// Card selection latch
	// ========================================
	// Non-empty image picks the virtual card, hard reset only
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			vsd_sel <= 1'b0;
		end else if (img_mounted) begin
			vsd_sel <= |img_size;
		end
	end

	// Physical card deselected and quiet when virtual
	assign sd_cs        = core_sd_cs | vsd_sel;
	assign sd_sck       = core_sd_sck & ~vsd_sel;
	assign sd_mosi      = core_sd_mosi & ~vsd_sel;
	assign vsd_ss       = core_sd_cs | ~vsd_sel;
	assign core_sd_miso = vsd_sel ? vsd_miso : card_miso;

	// ========================================
	// Activity detection
	// ========================================
	// Previous line samples
	always_ff @(posedge clk_sys) begin
		mosi_q <= core_sd_mosi;
		miso_q <= core_sd_miso;
	end

	assign toggle = (mosi_q ^ core_sd_mosi) | (miso_q ^ core_sd_miso);
	assign active = (hold_cnt != ACT_CNT_W'(ACT_HOLD_CYCLES));

	// Hold timer, parked at the expired value
	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			hold_cnt <= ACT_CNT_W'(ACT_HOLD_CYCLES);
		end else if (toggle) begin
			hold_cnt <= '0;
		end else if (active) begin
			hold_cnt <= hold_cnt + 1'b1;
		end
	end

	// Light only for virtual card traffic
	assign led_user = vsd_sel & active;

endmodule

// File: src/serial_router.sv
// ========================================
// Serial router
// Console or user port, RTS/CTS flow control
// ========================================
`timescale 1ns/1ns

module serial_router (
	input  logic                clk_sys,
	input  logic                sys_reset,
	input  multicomp_pkg::cfg_t cfg,
	// Core side
	input  logic                host_txd,
	input  logic                host_rts,
	output logic                host_rxd,
	output logic                host_cts,
	// Console UART pins
	input  logic                uart_rxd,
	input  logic                uart_cts,
	output logic                uart_txd,
	output logic                uart_rts,
	// User I/O port pins
	input  logic [6:0]          user_in,
	output logic [6:0]          user_out
);
	import multicomp_pkg::*;

	logic                    use_user;
	logic                    user_flow;
	logic                    sel_cts;
	logic                    settled;
	logic [SETTLE_CNT_W-1:0] settle_cnt;

	assign use_user  = (cfg.port == PORT_USER);
	assign user_flow = use_user & cfg.flow_en;

	// ========================================
	// CTS settling delay after reset
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			settled    <= 1'b0;
			settle_cnt <= '0;
		end else if (!settled) begin
			if (settle_cnt == SETTLE_CNT_W'(CTS_SETTLE_CYCLES - 1)) begin
				settled <= 1'b1;
			end else begin
				settle_cnt <= settle_cnt + 1'b1;
			end
		end
	end

	// ========================================
	// Pin routing
	// ========================================
	// RX back to the core from the chosen port
	assign host_rxd = use_user ? user_in[0] : uart_rxd;

	// CTS source, user port uses pin 3
	assign sel_cts  = use_user ? user_in[3] : uart_cts;
	// Held off until settled and flow control on
	assign host_cts = (cfg.flow_en & settled) ? sel_cts : 1'b0;

	// Console port idles high when not in use
	assign uart_txd = use_user ? 1'b1 : host_txd;
	assign uart_rts = (use_user | ~cfg.flow_en) ? 1'b1 : host_rts;

	// User port bits
	always_comb begin
		user_out    = '0;
		// RX input enable
		user_out[0] = use_user;
		// TX, idle high
		user_out[1] = use_user ? host_txd : 1'b1;
		// RTS, idle high
		user_out[2] = user_flow ? host_rts : 1'b1;
		// CTS input enable
		user_out[3] = user_flow;
	end

endmodule
